//--- include/sha2_defines.svh
/* SHA-2 engine widths and counts */

`ifndef SHA2_DEFINES_SVH
`define SHA2_DEFINES_SVH

// input beat and internal word
`define SHA2_DATA_W 64

// output digest bus
`define SHA2_DIGEST_W 512

// beats per block, schedule depth
`define SHA2_BLOCK_WORDS 16

// hash words a to h
`define SHA2_STATE_WORDS 8

// round index, up to 79
`define SHA2_ROUND_W 7

`endif

//--- rtl/sha2_pkg.sv
/* SHA-2 engine types */

package sha2_pkg;

    // msb set means 64-bit words and 80 rounds
    typedef enum logic [1:0] {
        SHA_224 = 2'b00,
        SHA_256 = 2'b01,
        SHA_384 = 2'b10,
        SHA_512 = 2'b11
    } mode_t;

    typedef enum logic [2:0] {
        CTRL_IDLE   = 3'd0,
        CTRL_LOAD   = 3'd1,
        CTRL_ROUND  = 3'd2,
        CTRL_UPDATE = 3'd3,
        CTRL_DONE   = 3'd4
    } ctrl_state_t;

endpackage

//--- rtl/sha2_round_const.sv
/* SHA-2 round constants and initial hash */

`timescale 1ns/1ns

`include "sha2_defines.svh"

module sha2_round_const (
    input  sha2_pkg::mode_t                                      mode_i,
    input  logic [`SHA2_ROUND_W-1:0]                             round_idx_i,
    output logic [`SHA2_DATA_W-1:0]                              round_k_o,
    output logic [`SHA2_STATE_WORDS-1:0][`SHA2_DATA_W-1:0]       init_hash_o
);

    // SHA-512 table, 32-bit modes take the upper halves
    localparam logic [`SHA2_DATA_W-1:0] K [80] = '{
        64'h428a2f98_d728ae22, 64'h71374491_23ef65cd, 64'hb5c0fbcf_ec4d3b2f, 64'he9b5dba5_8189dbbc,
        64'h3956c25b_f348b538, 64'h59f111f1_b605d019, 64'h923f82a4_af194f9b, 64'hab1c5ed5_da6d8118,
        64'hd807aa98_a3030242, 64'h12835b01_45706fbe, 64'h243185be_4ee4b28c, 64'h550c7dc3_d5ffb4e2,
        64'h72be5d74_f27b896f, 64'h80deb1fe_3b1696b1, 64'h9bdc06a7_25c71235, 64'hc19bf174_cf692694,
        64'he49b69c1_9ef14ad2, 64'hefbe4786_384f25e3, 64'h0fc19dc6_8b8cd5b5, 64'h240ca1cc_77ac9c65,
        64'h2de92c6f_592b0275, 64'h4a7484aa_6ea6e483, 64'h5cb0a9dc_bd41fbd4, 64'h76f988da_831153b5,
        64'h983e5152_ee66dfab, 64'ha831c66d_2db43210, 64'hb00327c8_98fb213f, 64'hbf597fc7_beef0ee4,
        64'hc6e00bf3_3da88fc2, 64'hd5a79147_930aa725, 64'h06ca6351_e003826f, 64'h14292967_0a0e6e70,
        64'h27b70a85_46d22ffc, 64'h2e1b2138_5c26c926, 64'h4d2c6dfc_5ac42aed, 64'h53380d13_9d95b3df,
        64'h650a7354_8baf63de, 64'h766a0abb_3c77b2a8, 64'h81c2c92e_47edaee6, 64'h92722c85_1482353b,
        64'ha2bfe8a1_4cf10364, 64'ha81a664b_bc423001, 64'hc24b8b70_d0f89791, 64'hc76c51a3_0654be30,
        64'hd192e819_d6ef5218, 64'hd6990624_5565a910, 64'hf40e3585_5771202a, 64'h106aa070_32bbd1b8,
        64'h19a4c116_b8d2d0c8, 64'h1e376c08_5141ab53, 64'h2748774c_df8eeb99, 64'h34b0bcb5_e19b48a8,
        64'h391c0cb3_c5c95a63, 64'h4ed8aa4a_e3418acb, 64'h5b9cca4f_7763e373, 64'h682e6ff3_d6b2b8a3,
        64'h748f82ee_5defb2fc, 64'h78a5636f_43172f60, 64'h84c87814_a1f0ab72, 64'h8cc70208_1a6439ec,
        64'h90befffa_23631e28, 64'ha4506ceb_de82bde9, 64'hbef9a3f7_b2c67915, 64'hc67178f2_e372532b,
        64'hca273ece_ea26619c, 64'hd186b8c7_21c0c207, 64'heada7dd6_cde0eb1e, 64'hf57d4f7f_ee6ed178,
        64'h06f067aa_72176fba, 64'h0a637dc5_a2c898a6, 64'h113f9804_bef90dae, 64'h1b710b35_131c471b,
        64'h28db77f5_23047d84, 64'h32caab7b_40c72493, 64'h3c9ebe0a_15c9bebc, 64'h431d67c4_9c100d4c,
        64'h4cc5d4be_cb3e42b6, 64'h597f299c_fc657e2a, 64'h5fcb6fab_3ad6faec, 64'h6c44198c_4a475817
    };

    // word 0 is a
    localparam logic [`SHA2_DATA_W-1:0] IV_512 [`SHA2_STATE_WORDS] = '{
        64'h6a09e667_f3bcc908, 64'hbb67ae85_84caa73b, 64'h3c6ef372_fe94f82b, 64'ha54ff53a_5f1d36f1,
        64'h510e527f_ade682d1, 64'h9b05688c_2b3e6c1f, 64'h1f83d9ab_fb41bd6b, 64'h5be0cd19_137e2179
    };

    localparam logic [`SHA2_DATA_W-1:0] IV_384 [`SHA2_STATE_WORDS] = '{
        64'hcbbb9d5d_c1059ed8, 64'h629a292a_367cd507, 64'h9159015a_3070dd17, 64'h152fecd8_f70e5939,
        64'h67332667_ffc00b31, 64'h8eb44a87_68581511, 64'hdb0c2e0d_64f98fa7, 64'h47b5481d_befa4fa4
    };

    always_comb begin
        if (mode_i[1]) begin
            round_k_o = K[round_idx_i];
        end else begin
            round_k_o = {32'b0, K[round_idx_i][63:32]};
        end
    end

    always_comb begin
        for (int i = 0; i < `SHA2_STATE_WORDS; i++) begin
            case (mode_i)
                sha2_pkg::SHA_224: init_hash_o[i] = {32'b0, IV_384[i][31:0]};  // low halves
                sha2_pkg::SHA_256: init_hash_o[i] = {32'b0, IV_512[i][63:32]};
                sha2_pkg::SHA_384: init_hash_o[i] = IV_384[i];
                default:           init_hash_o[i] = IV_512[i];
            endcase
        end
    end

endmodule

//--- rtl/sha2_msg_sched.sv
/* SHA-2 message schedule */

`timescale 1ns/1ns

`include "sha2_defines.svh"

module sha2_msg_sched (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    input  sha2_pkg::mode_t             mode_i,
    input  logic [`SHA2_DATA_W-1:0]     in_data_i,
    input  logic                        sched_load_i,
    input  logic                        round_en_i,
    input  logic [`SHA2_ROUND_W-1:0]    round_idx_i,
    output logic [`SHA2_DATA_W-1:0]     sched_word_o
);

    logic                                              wide;
    logic [`SHA2_BLOCK_WORDS-1:0][`SHA2_DATA_W-1:0]    w_q;
    logic [`SHA2_DATA_W-1:0]                           beat_be;
    logic [`SHA2_DATA_W-1:0]                           w_next;

    function automatic logic [`SHA2_DATA_W-1:0] rotr(input logic [`SHA2_DATA_W-1:0] x,
                                                     input int unsigned n, input logic wd);
        logic [31:0] lo;
        lo = (x[31:0] >> n) | (x[31:0] << (32 - n));
        return wd ? ((x >> n) | (x << (64 - n))) : {32'b0, lo};
    endfunction

    assign wide = mode_i[1];

    // stream order to big-endian word
    assign beat_be = wide ? {<<8{in_data_i}} : {32'b0, {<<8{in_data_i[31:0]}}};

    // W[t] from the window W[t-16..t-1], w_q[0] oldest
    always_comb begin
        logic [`SHA2_DATA_W-1:0] s0;
        logic [`SHA2_DATA_W-1:0] s1;
        logic [`SHA2_DATA_W-1:0] sum;
        s0 = wide ? rotr(w_q[1], 1, 1'b1) ^ rotr(w_q[1], 8, 1'b1) ^ (w_q[1] >> 7)
                  : rotr(w_q[1], 7, 1'b0) ^ rotr(w_q[1], 18, 1'b0) ^ (w_q[1] >> 3);
        s1 = wide ? rotr(w_q[14], 19, 1'b1) ^ rotr(w_q[14], 61, 1'b1) ^ (w_q[14] >> 6)
                  : rotr(w_q[14], 17, 1'b0) ^ rotr(w_q[14], 19, 1'b0) ^ (w_q[14] >> 10);
        sum = s1 + w_q[9] + s0 + w_q[0];
        w_next = wide ? sum : {32'b0, sum[31:0]};
    end

    assign sched_word_o = (round_idx_i < `SHA2_BLOCK_WORDS) ? w_q[round_idx_i[3:0]] : w_next;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            w_q <= '0;
        end else if (sched_load_i) begin
            w_q <= {beat_be, w_q[`SHA2_BLOCK_WORDS-1:1]};
        end else if (round_en_i && round_idx_i >= `SHA2_BLOCK_WORDS) begin
            w_q <= {w_next, w_q[`SHA2_BLOCK_WORDS-1:1]};  // slide window
        end
    end

endmodule

//--- rtl/sha2_compress.sv
/* SHA-2 compression and chaining state */

`timescale 1ns/1ns

`include "sha2_defines.svh"

module sha2_compress (
    input  logic                                                clk_i,
    input  logic                                                rst_n_i,
    input  sha2_pkg::mode_t                                     mode_i,
    input  logic [`SHA2_STATE_WORDS-1:0][`SHA2_DATA_W-1:0]      init_hash_i,
    input  logic [`SHA2_DATA_W-1:0]                             round_k_i,
    input  logic [`SHA2_DATA_W-1:0]                             sched_word_i,
    input  logic                                                msg_start_i,
    input  logic                                                block_start_i,
    input  logic                                                round_en_i,
    input  logic                                                state_update_i,
    output logic [`SHA2_STATE_WORDS-1:0][`SHA2_DATA_W-1:0]      hash_state_o
);

    logic                                                wide;
    logic [`SHA2_STATE_WORDS-1:0][`SHA2_DATA_W-1:0]      chain_q;
    logic [`SHA2_STATE_WORDS-1:0][`SHA2_DATA_W-1:0]      work_q;  // a at index 0
    logic [`SHA2_DATA_W-1:0]                             big_s0;
    logic [`SHA2_DATA_W-1:0]                             big_s1;
    logic [`SHA2_DATA_W-1:0]                             ch;
    logic [`SHA2_DATA_W-1:0]                             maj;
    logic [`SHA2_DATA_W-1:0]                             t1;
    logic [`SHA2_DATA_W-1:0]                             t2;

    function automatic logic [`SHA2_DATA_W-1:0] rotr(input logic [`SHA2_DATA_W-1:0] x,
                                                     input int unsigned n, input logic wd);
        logic [31:0] lo;
        lo = (x[31:0] >> n) | (x[31:0] << (32 - n));
        return wd ? ((x >> n) | (x << (64 - n))) : {32'b0, lo};
    endfunction

    function automatic logic [`SHA2_DATA_W-1:0] fit(input logic [`SHA2_DATA_W-1:0] x,
                                                    input logic wd);
        return wd ? x : {32'b0, x[31:0]};
    endfunction

    assign wide = mode_i[1];

    assign big_s0 = wide ? rotr(work_q[0], 28, 1'b1) ^ rotr(work_q[0], 34, 1'b1)
                           ^ rotr(work_q[0], 39, 1'b1)
                         : rotr(work_q[0], 2, 1'b0) ^ rotr(work_q[0], 13, 1'b0)
                           ^ rotr(work_q[0], 22, 1'b0);
    assign big_s1 = wide ? rotr(work_q[4], 14, 1'b1) ^ rotr(work_q[4], 18, 1'b1)
                           ^ rotr(work_q[4], 41, 1'b1)
                         : rotr(work_q[4], 6, 1'b0) ^ rotr(work_q[4], 11, 1'b0)
                           ^ rotr(work_q[4], 25, 1'b0);

    assign ch  = (work_q[4] & work_q[5]) ^ (~work_q[4] & work_q[6]);
    assign maj = (work_q[0] & work_q[1]) ^ (work_q[0] & work_q[2]) ^ (work_q[1] & work_q[2]);
    assign t1  = work_q[7] + big_s1 + ch + round_k_i + sched_word_i;
    assign t2  = big_s0 + maj;

    assign hash_state_o = chain_q;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            chain_q <= '0;
            work_q  <= '0;
        end else if (msg_start_i) begin
            chain_q <= init_hash_i;  // first block starts from the IV too
            work_q  <= init_hash_i;
        end else if (block_start_i) begin
            work_q <= chain_q;
        end else if (round_en_i) begin
            work_q <= {work_q[6:4], fit(work_q[3] + t1, wide), work_q[2:0], fit(t1 + t2, wide)};
        end else if (state_update_i) begin
            for (int i = 0; i < `SHA2_STATE_WORDS; i++) begin
                chain_q[i] <= fit(chain_q[i] + work_q[i], wide);  // feed-forward
            end
        end
    end

endmodule

//--- rtl/sha2_hash_ctrl.sv
/* SHA-2 engine controller */

`timescale 1ns/1ns

`include "sha2_defines.svh"

module sha2_hash_ctrl (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    input  sha2_pkg::mode_t             in_mode_i,
    input  logic                        in_last_i,
    input  logic                        in_valid_i,
    input  logic                        out_valid_i,
    output logic                        in_ready_o,
    output sha2_pkg::mode_t             mode_o,
    output logic                        sched_load_o,
    output logic                        block_start_o,
    output logic                        msg_start_o,
    output logic                        round_en_o,
    output logic                        state_update_o,
    output logic                        digest_done_o,
    output logic [`SHA2_ROUND_W-1:0]    round_idx_o
);

    localparam int BEAT_W = $clog2(`SHA2_BLOCK_WORDS);
    localparam logic [`SHA2_ROUND_W-1:0] LAST_RND_32 = 63;
    localparam logic [`SHA2_ROUND_W-1:0] LAST_RND_64 = 79;

    sha2_pkg::ctrl_state_t        state_q;
    sha2_pkg::mode_t              mode_q;
    logic                         last_q;
    logic [BEAT_W-1:0]            beat_cnt_q;
    logic [`SHA2_ROUND_W-1:0]     round_cnt_q;
    logic                         accept;
    logic                         beat_last;
    logic                         round_last;

    // no new message while a digest waits
    assign in_ready_o = (state_q == sha2_pkg::CTRL_LOAD)
                        || (state_q == sha2_pkg::CTRL_IDLE && !out_valid_i);
    assign accept     = in_valid_i && in_ready_o;
    assign beat_last  = beat_cnt_q == BEAT_W'(`SHA2_BLOCK_WORDS - 1);
    assign round_last = round_cnt_q == (mode_q[1] ? LAST_RND_64 : LAST_RND_32);

    always_comb begin
        if (state_q == sha2_pkg::CTRL_IDLE) begin
            mode_o = in_mode_i;  // first beat sees the new mode
        end else begin
            mode_o = mode_q;
        end
    end

    assign sched_load_o   = accept;
    assign msg_start_o    = accept && state_q == sha2_pkg::CTRL_IDLE;
    assign block_start_o  = accept && beat_cnt_q == '0;
    assign round_en_o     = state_q == sha2_pkg::CTRL_ROUND;
    assign round_idx_o    = round_cnt_q;
    assign state_update_o = state_q == sha2_pkg::CTRL_UPDATE;
    assign digest_done_o  = state_q == sha2_pkg::CTRL_DONE;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q     <= sha2_pkg::CTRL_IDLE;
            mode_q      <= sha2_pkg::SHA_224;
            last_q      <= 1'b0;
            beat_cnt_q  <= '0;
            round_cnt_q <= '0;
        end else begin
            if (accept) begin
                beat_cnt_q <= beat_cnt_q + 1'b1;  // wraps after beat 15
            end
            if (msg_start_o) begin
                mode_q <= in_mode_i;
            end
            if (accept && beat_last) begin
                last_q <= in_last_i;
            end
            round_cnt_q <= (round_en_o && !round_last) ? round_cnt_q + 1'b1 : '0;

            case (state_q)
                sha2_pkg::CTRL_IDLE:   if (accept) state_q <= sha2_pkg::CTRL_LOAD;
                sha2_pkg::CTRL_LOAD:   if (accept && beat_last) state_q <= sha2_pkg::CTRL_ROUND;
                sha2_pkg::CTRL_ROUND:  if (round_last) state_q <= sha2_pkg::CTRL_UPDATE;
                sha2_pkg::CTRL_UPDATE: state_q <= last_q ? sha2_pkg::CTRL_DONE
                                                         : sha2_pkg::CTRL_LOAD;
                default:               state_q <= sha2_pkg::CTRL_IDLE;
            endcase
        end
    end

endmodule

//--- rtl/sha2_digest_out.sv
/* SHA-2 digest output register */

`timescale 1ns/1ns

`include "sha2_defines.svh"

module sha2_digest_out (
    input  logic                                            clk_i,
    input  logic                                            rst_n_i,
    input  sha2_pkg::mode_t                                 mode_i,
    input  logic [`SHA2_STATE_WORDS-1:0][`SHA2_DATA_W-1:0]  hash_state_i,
    input  logic                                            digest_done_i,
    input  logic                                            out_ready_i,
    output logic [`SHA2_DIGEST_W-1:0]                       out_data_o,
    output logic                                            out_valid_o
);

    logic [3:0]                  n_words;
    logic [`SHA2_DIGEST_W-1:0]   packed_dig;

    always_comb begin
        case (mode_i)
            sha2_pkg::SHA_224: n_words = 4'd7;
            sha2_pkg::SHA_384: n_words = 4'd6;
            default:           n_words = 4'd8;
        endcase
    end

    // word 0 ends up most significant, zero above
    always_comb begin
        packed_dig = '0;
        for (int i = 0; i < `SHA2_STATE_WORDS; i++) begin
            if (i < n_words && mode_i[1]) begin
                packed_dig[(n_words - 1 - i) * 64 +: 64] = hash_state_i[i];
            end else if (i < n_words) begin
                packed_dig[(n_words - 1 - i) * 32 +: 32] = hash_state_i[i][31:0];
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            out_data_o  <= '0;
            out_valid_o <= 1'b0;
        end else if (digest_done_i) begin
            out_data_o  <= packed_dig;
            out_valid_o <= 1'b1;
        end else if (out_valid_o && out_ready_i) begin
            out_data_o  <= '0;  // consumed
            out_valid_o <= 1'b0;
        end
    end

endmodule

//--- rtl/sha2_core_top.sv
/* SHA-2 streaming hash engine */

`timescale 1ns/1ns

`include "sha2_defines.svh"

module sha2_core_top (
    input  logic                         clk_i,
    input  logic                         rst_n_i,
    input  sha2_pkg::mode_t              in_mode_i,
    input  logic                         in_last_i,
    input  logic [`SHA2_DATA_W-1:0]      in_data_i,
    input  logic                         in_valid_i,
    output logic                         in_ready_o,
    output logic [`SHA2_DIGEST_W-1:0]    out_data_o,
    output logic                         out_valid_o,
    input  logic                         out_ready_i
);

    sha2_pkg::mode_t                                     mode;
    logic                                                sched_load;
    logic                                                block_start;
    logic                                                msg_start;
    logic                                                round_en;
    logic                                                state_update;
    logic                                                digest_done;
    logic [`SHA2_ROUND_W-1:0]                            round_idx;
    logic [`SHA2_DATA_W-1:0]                             round_k;
    logic [`SHA2_DATA_W-1:0]                             sched_word;
    logic [`SHA2_STATE_WORDS-1:0][`SHA2_DATA_W-1:0]      init_hash;
    logic [`SHA2_STATE_WORDS-1:0][`SHA2_DATA_W-1:0]      hash_state;

    sha2_hash_ctrl sha2_hash_ctrl_i (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .in_mode_i      (in_mode_i),
        .in_last_i      (in_last_i),
        .in_valid_i     (in_valid_i),
        .out_valid_i    (out_valid_o),
        .in_ready_o     (in_ready_o),
        .mode_o         (mode),
        .sched_load_o   (sched_load),
        .block_start_o  (block_start),
        .msg_start_o    (msg_start),
        .round_en_o     (round_en),
        .state_update_o (state_update),
        .digest_done_o  (digest_done),
        .round_idx_o    (round_idx)
    );

    sha2_round_const sha2_round_const_i (
        .mode_i      (mode),
        .round_idx_i (round_idx),
        .round_k_o   (round_k),
        .init_hash_o (init_hash)
    );

    sha2_msg_sched sha2_msg_sched_i (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .mode_i       (mode),
        .in_data_i    (in_data_i),
        .sched_load_i (sched_load),
        .round_en_i   (round_en),
        .round_idx_i  (round_idx),
        .sched_word_o (sched_word)
    );

    sha2_compress sha2_compress_i (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .mode_i         (mode),
        .init_hash_i    (init_hash),
        .round_k_i      (round_k),
        .sched_word_i   (sched_word),
        .msg_start_i    (msg_start),
        .block_start_i  (block_start),
        .round_en_i     (round_en),
        .state_update_i (state_update),
        .hash_state_o   (hash_state)
    );

    sha2_digest_out sha2_digest_out_i (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .mode_i        (mode),
        .hash_state_i  (hash_state),
        .digest_done_i (digest_done),
        .out_ready_i   (out_ready_i),
        .out_data_o    (out_data_o),
        .out_valid_o   (out_valid_o)
    );

endmodule

//--- verif/sha2_tb.sv
/* SHA-2 engine testbench */

`timescale 1ns/1ns

`include "sha2_defines.svh"

module sha2_tb;

    localparam int TIMEOUT = 400;  // cycles per wait

    localparam logic [`SHA2_DIGEST_W-1:0] DIG_224_ABC =
        224'h23097d22_3405d822_8642a477_bda255b3_2aadbce4_bda0b3f7_e36c9da7;
    localparam logic [`SHA2_DIGEST_W-1:0] DIG_256_ABC =
        256'hba7816bf_8f01cfea_414140de_5dae2223_b00361a3_96177a9c_b410ff61_f20015ad;
    localparam logic [`SHA2_DIGEST_W-1:0] DIG_256_EMPTY =
        256'he3b0c442_98fc1c14_9afbf4c8_996fb924_27ae41e4_649b934c_a495991b_7852b855;
    localparam logic [`SHA2_DIGEST_W-1:0] DIG_256_TWO =
        256'h248d6a61_d20638b8_e5c02693_0c3e6039_a33ce459_64ff2167_f6ecedd4_19db06c1;
    localparam logic [`SHA2_DIGEST_W-1:0] DIG_384_ABC =
        {192'hcb00753f_45a35e8b_b5a03d69_9ac65007_272c32ab_0eded163,
         192'h1a8b605a_43ff5bed_8086072b_a1e7cc23_58baeca1_34c825a7};
    localparam logic [`SHA2_DIGEST_W-1:0] DIG_512_ABC =
        {256'hddaf35a1_93617aba_cc417349_ae204131_12e6fa4e_89a97ea2_0a9eeee6_4b55d39a,
         256'h2192992a_274fc1a8_36ba3c23_a3feebbd_454d4423_643ce80e_2a9ac94f_a54ca49f};

    localparam string MSG_TWO = "abcdbcdecdefdefgefghfghighijhijkijkljklmklmnlmnomnopnopq";

    logic                          clk_i;
    logic                          rst_n_i;
    sha2_pkg::mode_t               in_mode_i;
    logic                          in_last_i;
    logic [`SHA2_DATA_W-1:0]       in_data_i;
    logic                          in_valid_i;
    logic                          in_ready_o;
    logic [`SHA2_DIGEST_W-1:0]     out_data_o;
    logic                          out_valid_o;
    logic                          out_ready_i;

    integer                        seed;
    int                            errors;
    int                            vectors_run;
    logic                          timed_out;
    byte unsigned                  padded[$];

    // vector table, one entry per index
    string                         name_q[$];
    sha2_pkg::mode_t               mode_q[$];
    int                            blocks_q[$];
    string                         msg_q[$];
    logic                          gaps_q[$];
    logic                          stall_q[$];
    logic [`SHA2_DIGEST_W-1:0]     exp_q[$];

    sha2_core_top sha2_core_top_i (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .in_mode_i   (in_mode_i),
        .in_last_i   (in_last_i),
        .in_data_i   (in_data_i),
        .in_valid_i  (in_valid_i),
        .in_ready_o  (in_ready_o),
        .out_data_o  (out_data_o),
        .out_valid_o (out_valid_o),
        .out_ready_i (out_ready_i)
    );

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    task automatic add_vector(input string name, input sha2_pkg::mode_t mode, input int blocks,
                              input string msg, input logic gaps, input logic stall,
                              input logic [`SHA2_DIGEST_W-1:0] expected);
        name_q.push_back(name);
        mode_q.push_back(mode);
        blocks_q.push_back(blocks);
        msg_q.push_back(msg);
        gaps_q.push_back(gaps);
        stall_q.push_back(stall);
        exp_q.push_back(expected);
    endtask

    task automatic report_mismatch(input string name, input logic [`SHA2_DIGEST_W-1:0] expected,
                                   input logic [`SHA2_DIGEST_W-1:0] actual);
        errors++;
        $display("FAIL %s expected %0h actual %0h", name, expected, actual);
    endtask

    // host side padding: 0x80, zeros, bit length at the end
    task automatic build_padded(input string msg, input int blocks, input logic wide);
        int              total;
        longint unsigned bit_len;
        total   = blocks * (wide ? 128 : 64);
        bit_len = msg.len() * 8;
        padded.delete();
        for (int i = 0; i < total; i++) begin
            padded.push_back(8'h00);
        end
        for (int i = 0; i < msg.len(); i++) begin
            padded[i] = msg[i];
        end
        padded[msg.len()] = 8'h80;
        for (int i = 0; i < 8; i++) begin
            padded[total - 1 - i] = bit_len[8*i +: 8];
        end
    endtask

    // called just after a falling edge
    task automatic send_beat(input string name, input logic [`SHA2_DATA_W-1:0] beat,
                             input logic last, input sha2_pkg::mode_t mode, input logic gaps);
        int idle;
        int waited;
        if (gaps) begin
            idle       = {$random(seed)} % 4;
            in_valid_i = 1'b0;
            in_data_i  = {$random(seed), $random(seed)};  // junk while idle
            repeat (idle) @(negedge clk_i);
        end
        in_valid_i = 1'b1;
        in_data_i  = beat;
        in_mode_i  = mode;
        in_last_i  = last;
        waited     = 0;
        while (!in_ready_o && waited < TIMEOUT) begin
            @(negedge clk_i);
            waited++;
        end
        if (!in_ready_o) begin
            errors++;
            timed_out  = 1'b1;
            in_valid_i = 1'b0;
            $display("ERROR: %s never raised in_ready_o for an input beat", name);
        end else begin
            @(negedge clk_i);  // accepted on the rising edge in between
            in_valid_i = 1'b0;
        end
    endtask

    task automatic collect_digest(input int idx);
        int                        waited;
        int                        hold;
        logic [`SHA2_DIGEST_W-1:0] held;
        waited = 0;
        while (!out_valid_o && waited < TIMEOUT) begin
            @(negedge clk_i);
            waited++;
        end
        if (!out_valid_o) begin
            errors++;
            timed_out = 1'b1;
            $display("ERROR: %s produced no digest, out_valid_o stayed low", name_q[idx]);
        end else begin
            if (out_data_o !== exp_q[idx]) report_mismatch(name_q[idx], exp_q[idx], out_data_o);
            if (stall_q[idx]) begin
                held = out_data_o;
                hold = 1 + {$random(seed)} % 8;
                repeat (hold) begin
                    @(negedge clk_i);
                    if (out_valid_o !== 1'b1)
                        report_mismatch({name_q[idx], " valid held"}, 1, out_valid_o);
                    if (out_data_o !== held)
                        report_mismatch({name_q[idx], " data held"}, held, out_data_o);
                    if (in_ready_o !== 1'b0)
                        report_mismatch({name_q[idx], " in_ready blocked"}, 0, in_ready_o);
                end
                out_ready_i = 1'b1;
            end
            @(negedge clk_i);
            if (out_valid_o !== 1'b0)
                report_mismatch({name_q[idx], " consumed"}, 0, out_valid_o);
        end
    endtask

    task automatic run_vector(input int idx);
        logic                    wide;
        int                      bpb;
        int                      n_beats;
        logic [`SHA2_DATA_W-1:0] beat;
        wide    = mode_q[idx][1];
        bpb     = wide ? 8 : 4;  // 32-bit modes use the low four bytes
        n_beats = blocks_q[idx] * `SHA2_BLOCK_WORDS;
        build_padded(msg_q[idx], blocks_q[idx], wide);
        out_ready_i = !stall_q[idx];
        for (int b = 0; b < n_beats && !timed_out; b++) begin
            beat = '0;
            for (int j = 0; j < bpb; j++) begin
                beat[8*j +: 8] = padded[b*bpb + j];  // stream byte 0 lowest
            end
            send_beat(name_q[idx], beat, b == n_beats - 1, mode_q[idx], gaps_q[idx]);
        end
        if (!timed_out) collect_digest(idx);
    endtask

    initial begin
        seed        = 32'h323b_3296;
        errors      = 0;
        vectors_run = 0;
        timed_out   = 1'b0;
        rst_n_i     = 1'b0;
        in_mode_i   = sha2_pkg::SHA_256;
        in_last_i   = 1'b0;
        in_data_i   = '0;
        in_valid_i  = 1'b0;
        out_ready_i = 1'b1;

        //         name                 mode               blk msg      gaps  stall expected
        add_vector("abc_224",           sha2_pkg::SHA_224, 1, "abc",    1'b0, 1'b0, DIG_224_ABC);
        add_vector("abc_256",           sha2_pkg::SHA_256, 1, "abc",    1'b0, 1'b0, DIG_256_ABC);
        add_vector("abc_384",           sha2_pkg::SHA_384, 1, "abc",    1'b0, 1'b0, DIG_384_ABC);
        add_vector("abc_512",           sha2_pkg::SHA_512, 1, "abc",    1'b0, 1'b0, DIG_512_ABC);
        add_vector("two_block_256",     sha2_pkg::SHA_256, 2, MSG_TWO,  1'b0, 1'b0, DIG_256_TWO);
        add_vector("empty_256",         sha2_pkg::SHA_256, 1, "",       1'b0, 1'b0, DIG_256_EMPTY);
        add_vector("abc_256_gaps",      sha2_pkg::SHA_256, 1, "abc",    1'b1, 1'b0, DIG_256_ABC);
        add_vector("two_block_gaps",    sha2_pkg::SHA_256, 2, MSG_TWO,  1'b1, 1'b0, DIG_256_TWO);
        add_vector("abc_512_gaps",      sha2_pkg::SHA_512, 1, "abc",    1'b1, 1'b0, DIG_512_ABC);
        add_vector("empty_256_gaps",    sha2_pkg::SHA_256, 1, "",       1'b1, 1'b0, DIG_256_EMPTY);
        add_vector("abc_384_stall",     sha2_pkg::SHA_384, 1, "abc",    1'b0, 1'b1, DIG_384_ABC);
        add_vector("abc_224_stall",     sha2_pkg::SHA_224, 1, "abc",    1'b1, 1'b1, DIG_224_ABC);
        add_vector("two_block_stall",   sha2_pkg::SHA_256, 2, MSG_TWO,  1'b0, 1'b1, DIG_256_TWO);
        add_vector("abc_512_after",     sha2_pkg::SHA_512, 1, "abc",    1'b0, 1'b0, DIG_512_ABC);
        add_vector("abc_224_after",     sha2_pkg::SHA_224, 1, "abc",    1'b1, 1'b0, DIG_224_ABC);
        add_vector("abc_384_after",     sha2_pkg::SHA_384, 1, "abc",    1'b0, 1'b0, DIG_384_ABC);

        repeat (8) @(posedge clk_i);
        @(negedge clk_i);
        rst_n_i = 1'b1;
        @(negedge clk_i);

        if (out_valid_o !== 1'b0) report_mismatch("reset out_valid_o", 0, out_valid_o);
        if (out_data_o !== '0) report_mismatch("reset out_data_o", 0, out_data_o);
        if (in_ready_o !== 1'b1) report_mismatch("reset in_ready_o", 1, in_ready_o);

        for (int i = 0; i < name_q.size() && !timed_out; i++) begin
            run_vector(i);
            vectors_run++;
        end

        $display("%0d vectors run, %0d errors", vectors_run, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- files.f
+incdir+include
rtl/sha2_pkg.sv
rtl/sha2_round_const.sv
rtl/sha2_msg_sched.sv
rtl/sha2_compress.sv
rtl/sha2_hash_ctrl.sv
rtl/sha2_digest_out.sv
rtl/sha2_core_top.sv
verif/sha2_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = sha2_tb
FILELIST  = files.f
BUILD_DIR = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out=$$(./$(BUILD_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf $(BUILD_DIR)
